//--- armCore_config.svh
`ifndef ARMCORE_CONFIG_SVH
`define ARMCORE_CONFIG_SVH

// Widths fixed by the ISA
`define ARM_WORD_WIDTH      32
`define ARM_REG_ADDR_WIDTH  4
`define ARM_PC_STEP         32'd4    // One instruction word
`define ARM_PC_REG          4'd15    // R15 reads as PC+8

// Op field, Instr[27:26]
`define ARM_OP_DP           2'b00
`define ARM_OP_MEM          2'b01
`define ARM_OP_BRANCH       2'b10

// Cmd field of data processing, Instr[24:21]
`define ARM_FUNCT_AND       4'b0000
`define ARM_FUNCT_EOR       4'b0001
`define ARM_FUNCT_SUB       4'b0010
`define ARM_FUNCT_ADD       4'b0100
`define ARM_FUNCT_ORR       4'b1100
`define ARM_FUNCT_MOV       4'b1101

// Internal ALU operations
`define ARM_ALU_ADD         3'd0
`define ARM_ALU_SUB         3'd1
`define ARM_ALU_AND         3'd2
`define ARM_ALU_ORR         3'd3
`define ARM_ALU_EOR         3'd4
`define ARM_ALU_MOV         3'd5

// Immediate extension selects
`define ARM_IMM_DP8         2'b00    // Zero-extended imm8
`define ARM_IMM_MEM12       2'b01    // Zero-extended imm12
`define ARM_IMM_BR24        2'b10    // Sign-extended imm24, word offset

`define ARM_COND_AL         4'b1110

`endif

//--- armPkg.sv
`include "armCore_config.svh"

package armPkg;

   // Data word, address or instruction
   typedef logic [`ARM_WORD_WIDTH-1:0] word_t;

   // Index into the sixteen registers
   typedef logic [`ARM_REG_ADDR_WIDTH-1:0] regAddr_t;

   // Status flags, packed as N, Z, C, V from msb down
   typedef logic [3:0] flags_t;

   // Condition field, Instr[31:28]
   typedef logic [3:0] cond_t;

   // Internal ALU operation, see ARM_ALU_* codes
   typedef logic [2:0] aluOp_t;

   // Extension select, see ARM_IMM_* codes
   typedef logic [1:0] immSrc_t;

endpackage

//--- instrDecoder.sv
`timescale 1ns/1ps
`include "armCore_config.svh"

module instrDecoder import armPkg::*; (
   input  word_t      Instr,
   output logic       regWriteReq,
   output logic       memWriteReq,
   output logic       pcWriteReq,
   output logic       memToReg,
   output logic       aluSrc,
   output logic       memAccess,
   output logic [1:0] regSrc,      // Bit 0 reads R15 on A, bit 1 reads Rd on B
   output logic [1:0] flagWrite,   // Bit 1 for N,Z and bit 0 for C,V
   output immSrc_t    immSrc,
   output aluOp_t     aluOp
);

   logic [1:0] op;
   logic       immBit;     // I bit
   logic [3:0] cmd;
   logic       sBit;       // S for data processing, L for memory
   logic       linkBit;    // Set on BL, not supported
   regAddr_t   rd;
   logic       cmdOk;      // Cmd is one of the six kept
   logic       arith;      // ADD or SUB touch C and V
   logic       isDp;
   logic       isBranch;
   aluOp_t     dpAluOp;

   assign op      = Instr[27:26];
   assign immBit  = Instr[25];
   assign cmd     = Instr[24:21];
   assign sBit    = Instr[20];
   assign linkBit = Instr[24];
   assign rd      = Instr[15:12];

   // ALU decoder for data processing
   always_comb begin
      cmdOk   = 1'b1;
      dpAluOp = `ARM_ALU_ADD;
      case (cmd)
         `ARM_FUNCT_ADD: dpAluOp = `ARM_ALU_ADD;
         `ARM_FUNCT_SUB: dpAluOp = `ARM_ALU_SUB;
         `ARM_FUNCT_AND: dpAluOp = `ARM_ALU_AND;
         `ARM_FUNCT_ORR: dpAluOp = `ARM_ALU_ORR;
         `ARM_FUNCT_EOR: dpAluOp = `ARM_ALU_EOR;
         `ARM_FUNCT_MOV: dpAluOp = `ARM_ALU_MOV;
         default:        cmdOk   = 1'b0;    // Falls through as no-op
      endcase
   end

   // Main decoder, defaults describe a no-op
   always_comb begin
      regWriteReq = 1'b0;
      memWriteReq = 1'b0;
      memAccess   = 1'b0;
      memToReg    = 1'b0;
      aluSrc      = 1'b0;
      regSrc      = 2'b00;
      immSrc      = `ARM_IMM_DP8;
      isDp        = 1'b0;
      isBranch    = 1'b0;
      case (op)
         `ARM_OP_DP: begin
            isDp        = cmdOk;
            regWriteReq = cmdOk;
            aluSrc      = immBit;         // Imm8 or Rm
         end
         `ARM_OP_MEM: if (!immBit) begin  // Only immediate offsets
            memAccess = 1'b1;
            aluSrc    = 1'b1;
            immSrc    = `ARM_IMM_MEM12;
            if (sBit) begin               // LDR
               regWriteReq = 1'b1;
               memToReg    = 1'b1;
            end else begin                // STR
               memWriteReq = 1'b1;
               regSrc      = 2'b10;       // Store data from Rd
            end
         end
         `ARM_OP_BRANCH: if (!linkBit) begin
            isBranch = 1'b1;
            aluSrc   = 1'b1;
            regSrc   = 2'b01;             // Base is PC+8
            immSrc   = `ARM_IMM_BR24;
         end
         default: ;                       // Op 11 unsupported
      endcase
   end

   assign aluOp = isDp ? dpAluOp : `ARM_ALU_ADD;   // Address and target are sums

   // C and V only from arithmetic
   assign arith     = (cmd == `ARM_FUNCT_ADD) || (cmd == `ARM_FUNCT_SUB);
   assign flagWrite = isDp ? {sBit, sBit & arith} : 2'b00;

   // Writing R15 redirects the PC
   assign pcWriteReq = isBranch | (regWriteReq & (rd == `ARM_PC_REG));

endmodule

//--- condUnit.sv
`timescale 1ns/1ps
`include "armCore_config.svh"

module condUnit import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  word_t      Instr,
   input  flags_t     aluFlags,
   input  logic       regWriteReq,
   input  logic       memWriteReq,
   input  logic       pcWriteReq,
   input  logic       memAccess,
   input  logic [1:0] flagWrite,
   output logic       regWrite,
   output logic       MemWrite,
   output logic       MemStrobe,
   output logic       pcSrc
);

   cond_t      cond;
   flags_t     flags;     // Stored N, Z, C, V
   logic       n, z, c, v;
   logic       ge;        // Signed greater or equal
   logic       condEx;
   logic [1:0] flagEn;

   assign cond         = Instr[31:28];
   assign {n, z, c, v} = flags;
   assign ge           = (n == v);

   // Two halves so logic ops keep C and V
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else begin
         if (flagEn[1]) flags[3:2] <= aluFlags[3:2];   // N, Z
         if (flagEn[0]) flags[1:0] <= aluFlags[1:0];   // C, V
      end
   end

   always_comb begin
      case (cond)
         4'b0000:      condEx = z;             // EQ
         4'b0001:      condEx = ~z;            // NE
         4'b0010:      condEx = c;             // CS
         4'b0011:      condEx = ~c;            // CC
         4'b0100:      condEx = n;             // MI
         4'b0101:      condEx = ~n;            // PL
         4'b0110:      condEx = v;             // VS
         4'b0111:      condEx = ~v;            // VC
         4'b1000:      condEx = c & ~z;        // HI
         4'b1001:      condEx = ~c | z;        // LS
         4'b1010:      condEx = ge;            // GE
         4'b1011:      condEx = ~ge;           // LT
         4'b1100:      condEx = ~z & ge;       // GT
         4'b1101:      condEx = z | ~ge;       // LE
         `ARM_COND_AL: condEx = 1'b1;
         default:      condEx = 1'b0;          // Reserved code never executes
      endcase
   end

   // Every side effect waits on the condition
   assign flagEn    = flagWrite & {2{condEx}};
   assign regWrite  = regWriteReq & condEx;
   assign MemWrite  = memWriteReq & condEx;
   assign MemStrobe = memAccess & condEx;      // Loads and stores alike
   assign pcSrc     = pcWriteReq & condEx;

endmodule

//--- regFile.sv
`timescale 1ns/1ps
`include "armCore_config.svh"

module regFile import armPkg::*; (
   input  logic     clk,
   input  logic     writeEn,
   input  regAddr_t readAddrA,
   input  regAddr_t readAddrB,
   input  regAddr_t writeAddr,
   input  word_t    writeData,
   input  word_t    pcPlus8,
   output word_t    readDataA,
   output word_t    readDataB
);

   word_t regs [0:14];   // R0 to R14, R15 lives in the datapath

   // R15 writes go to the PC instead
   always_ff @(posedge clk) begin
      if (writeEn && (writeAddr != `ARM_PC_REG)) regs[writeAddr] <= writeData;
   end

   // Two combinational read ports
   assign readDataA = (readAddrA == `ARM_PC_REG) ? pcPlus8 : regs[readAddrA];
   assign readDataB = (readAddrB == `ARM_PC_REG) ? pcPlus8 : regs[readAddrB];

endmodule

//--- alu.sv
`timescale 1ns/1ps
`include "armCore_config.svh"

module alu import armPkg::*; (
   input  word_t  srcA,
   input  word_t  srcB,
   input  aluOp_t aluOp,
   output word_t  result,
   output flags_t aluFlags
);

   logic                      isSub;
   word_t                     bMod;      // srcB, inverted for SUB
   logic [`ARM_WORD_WIDTH:0]  sum;       // Carry out in the top bit
   logic                      neg, zero, carry, overflow;

   assign isSub = (aluOp == `ARM_ALU_SUB);
   assign bMod  = isSub ? ~srcB : srcB;

   // A - B as A + ~B + 1
   assign sum = {1'b0, srcA} + {1'b0, bMod} + {{`ARM_WORD_WIDTH{1'b0}}, isSub};

   always_comb begin
      case (aluOp)
         `ARM_ALU_ADD,
         `ARM_ALU_SUB: result = sum[`ARM_WORD_WIDTH-1:0];
         `ARM_ALU_AND: result = srcA & srcB;
         `ARM_ALU_ORR: result = srcA | srcB;
         `ARM_ALU_EOR: result = srcA ^ srcB;
         `ARM_ALU_MOV: result = srcB;              // Rn ignored
         default:      result = '0;
      endcase
   end

   assign neg   = result[`ARM_WORD_WIDTH-1];
   assign zero  = (result == '0);
   assign carry = sum[`ARM_WORD_WIDTH];            // High means no borrow on SUB

   // Same-sign operands giving an opposite-sign sum
   assign overflow = ~(srcA[`ARM_WORD_WIDTH-1] ^ bMod[`ARM_WORD_WIDTH-1])
                   & (srcA[`ARM_WORD_WIDTH-1] ^ sum[`ARM_WORD_WIDTH-1]);

   // C and V only matter on ADD and SUB, the decoder masks the rest
   assign aluFlags = {neg, zero, carry, overflow};

endmodule

//--- datapath.sv
`timescale 1ns/1ps
`include "armCore_config.svh"

module datapath import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  word_t      Instr,
   input  logic       regWrite,
   input  logic       pcSrc,
   input  logic       memToReg,
   input  logic       aluSrc,
   input  logic [1:0] regSrc,
   input  immSrc_t    immSrc,
   input  aluOp_t     aluOp,
   input  word_t      ReadData,
   output word_t      PC,
   output word_t      ALUResult,
   output word_t      WriteData,
   output flags_t     aluFlags
);

   word_t    pcNext, pcPlus4, pcPlus8;
   word_t    extImm;
   word_t    srcA, srcB;
   word_t    result;     // Write-back value
   regAddr_t readAddrA, readAddrB;

   // PC advances every cycle, no stall
   always_ff @(posedge clk or posedge reset) begin
      if (reset) PC <= '0;
      else       PC <= pcNext;
   end

   assign pcPlus4 = PC + `ARM_PC_STEP;
   assign pcPlus8 = pcPlus4 + `ARM_PC_STEP;   // Pipeline view of R15
   assign pcNext  = pcSrc ? result : pcPlus4;

   // Branch base is R15, store data comes from Rd
   assign readAddrA = regSrc[0] ? `ARM_PC_REG : Instr[19:16];
   assign readAddrB = regSrc[1] ? Instr[15:12] : Instr[3:0];

   regFile u_regFile (
      .clk       (clk),
      .writeEn   (regWrite),
      .readAddrA (readAddrA),
      .readAddrB (readAddrB),
      .writeAddr (Instr[15:12]),
      .writeData (result),
      .pcPlus8   (pcPlus8),
      .readDataA (srcA),
      .readDataB (WriteData)
   );

   always_comb begin
      case (immSrc)
         `ARM_IMM_DP8:   extImm = {24'b0, Instr[7:0]};
         `ARM_IMM_MEM12: extImm = {20'b0, Instr[11:0]};
         `ARM_IMM_BR24:  extImm = {{6{Instr[23]}}, Instr[23:0], 2'b00};  // Words to bytes
         default:        extImm = '0;
      endcase
   end

   assign srcB = aluSrc ? extImm : WriteData;   // Rm goes straight in, no shifter

   alu u_alu (
      .srcA     (srcA),
      .srcB     (srcB),
      .aluOp    (aluOp),
      .result   (ALUResult),
      .aluFlags (aluFlags)
   );

   // Loads return memory data
   assign result = memToReg ? ReadData : ALUResult;

endmodule

//--- armCore.sv
`timescale 1ns/1ps

module armCore import armPkg::*; (
   input  logic  clk,
   input  logic  reset,
   output word_t PC,
   input  word_t Instr,
   output logic  MemWrite,
   output logic  MemStrobe,
   output word_t ALUResult,
   output word_t WriteData,
   input  word_t ReadData
);

   logic       regWriteReq, memWriteReq, pcWriteReq;   // Before the condition
   logic       memToReg, aluSrc, memAccess;
   logic [1:0] regSrc;
   logic [1:0] flagWrite;
   immSrc_t    immSrc;
   aluOp_t     aluOp;
   flags_t     aluFlags;
   logic       regWrite, pcSrc;                        // After the condition

   instrDecoder u_instrDecoder (
      .Instr       (Instr),
      .regWriteReq (regWriteReq),
      .memWriteReq (memWriteReq),
      .pcWriteReq  (pcWriteReq),
      .memToReg    (memToReg),
      .aluSrc      (aluSrc),
      .memAccess   (memAccess),
      .regSrc      (regSrc),
      .flagWrite   (flagWrite),
      .immSrc      (immSrc),
      .aluOp       (aluOp)
   );

   condUnit u_condUnit (
      .clk         (clk),
      .reset       (reset),
      .Instr       (Instr),
      .aluFlags    (aluFlags),
      .regWriteReq (regWriteReq),
      .memWriteReq (memWriteReq),
      .pcWriteReq  (pcWriteReq),
      .memAccess   (memAccess),
      .flagWrite   (flagWrite),
      .regWrite    (regWrite),
      .MemWrite    (MemWrite),
      .MemStrobe   (MemStrobe),
      .pcSrc       (pcSrc)
   );

   datapath u_datapath (
      .clk       (clk),
      .reset     (reset),
      .Instr     (Instr),
      .regWrite  (regWrite),
      .pcSrc     (pcSrc),
      .memToReg  (memToReg),
      .aluSrc    (aluSrc),
      .regSrc    (regSrc),
      .immSrc    (immSrc),
      .aluOp     (aluOp),
      .ReadData  (ReadData),
      .PC        (PC),
      .ALUResult (ALUResult),
      .WriteData (WriteData),
      .aluFlags  (aluFlags)
   );

endmodule

//--- armCore_properties.sv
`timescale 1ns/1ps

module armCore_properties import armPkg::*; (
   input logic  clk,
   input logic  reset,
   input logic  MemWrite,
   input logic  MemStrobe,
   input word_t PC
);

   int failCount = 0;   // Number of failed assertions

   // A store is always a strobed access
   storeStrobed: assert property (@(posedge clk) disable iff (reset) MemWrite |-> MemStrobe)
      else begin
         failCount++;
         $error("MemWrite high without MemStrobe");
      end

   pcAligned: assert property (@(posedge clk) disable iff (reset) PC[1:0] == 2'b00)
      else begin
         failCount++;
         $error("PC not word aligned");
      end

   pcKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(PC))
      else begin
         failCount++;
         $error("PC has unknown bits");
      end

endmodule

bind armCore armCore_properties u_props (
   .clk       (clk),
   .reset     (reset),
   .MemWrite  (MemWrite),
   .MemStrobe (MemStrobe),
   .PC        (PC)
);

//--- armCore_checker.sv
`timescale 1ns/1ps

module armCore_checker import armPkg::*; (
   input logic  clk,
   input logic  reset,
   input logic  MemWrite,
   input logic  MemStrobe,
   input word_t ALUResult,
   input word_t WriteData
);

   word_t expAddr [$];    // Expected stores, oldest first
   word_t expData [$];
   word_t loadAddr [$];   // Expected load addresses in program order
   word_t wantAddr, wantData, wantLoad;
   int    passCount  = 0;
   int    failCount  = 0;
   int    extraCount = 0;
   int    storeIdx   = 0;
   int    loadIdx    = 0;

   task automatic expectStore(input word_t addr, input word_t data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   task automatic expectLoad(input word_t addr);
      loadAddr.push_back(addr);
   endtask

   function automatic int remaining();
      return expAddr.size() + loadAddr.size();
   endfunction

   // Mid-cycle sample while the access is stable
   always @(negedge clk) begin
      if (!reset && MemWrite) begin
         if (expAddr.size() == 0) begin
            extraCount++;
            $display("Unexpected extra store of %h to address %h at %0t",
                     WriteData, ALUResult, $time);
         end else begin
            wantAddr = expAddr.pop_front();
            wantData = expData.pop_front();
            if (ALUResult === wantAddr && WriteData === wantData && MemStrobe === 1'b1) begin
               passCount++;
               $display("Store %0d to %h: %h ok", storeIdx, ALUResult, WriteData);
            end else begin
               failCount++;
               $display("FAILED at %0t: store %0d expected %h to %h, got %h to %h strobe %b",
                        $time, storeIdx, wantData, wantAddr, WriteData, ALUResult,
                        MemStrobe);
            end
            storeIdx++;
         end
      end else if (!reset && MemStrobe) begin
         // Strobe without a write marks a load
         if (loadAddr.size() == 0) begin
            extraCount++;
            $display("Unexpected extra strobe at address %h at %0t", ALUResult, $time);
         end else begin
            wantLoad = loadAddr.pop_front();
            if (ALUResult === wantLoad) begin
               passCount++;
               $display("Load %0d from %h ok", loadIdx, ALUResult);
            end else begin
               failCount++;
               $display("FAILED at %0t: load %0d expected from %h, got from %h",
                        $time, loadIdx, wantLoad, ALUResult);
            end
            loadIdx++;
         end
      end
   end

endmodule

//--- armCore_tb.sv
`timescale 1ns/1ps

module armCore_tb import armPkg::*; ();

   logic  clk;
   logic  reset;
   logic  MemWrite, MemStrobe;
   word_t PC, Instr, ALUResult, WriteData, ReadData;

   word_t imem [0:63];    // Program words by byte address bits 7:2
   word_t dmem [0:255];   // Data words by byte address bits 9:2
   word_t pat  [0:511];   // Raw pattern records

   armCore dut (
      .clk       (clk),
      .reset     (reset),
      .PC        (PC),
      .Instr     (Instr),
      .MemWrite  (MemWrite),
      .MemStrobe (MemStrobe),
      .ALUResult (ALUResult),
      .WriteData (WriteData),
      .ReadData  (ReadData)
   );

   armCore_checker u_check (
      .clk       (clk),
      .reset     (reset),
      .MemWrite  (MemWrite),
      .MemStrobe (MemStrobe),
      .ALUResult (ALUResult),
      .WriteData (WriteData)
   );

   // Same-cycle memory answers
   assign Instr    = imem[PC[7:2]];
   assign ReadData = dmem[ALUResult[9:2]];

   always @(posedge clk) begin
      if (MemWrite) dmem[ALUResult[9:2]] <= WriteData;
   end

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      int    i;
      int    progLen;
      int    cycles;
      int    cycleLimit;
      logic  loadError;
      logic  timedOut;
      reset     <= 1'b1;
      progLen   = 0;
      loadError = 1'b0;
      // Unused program slots hold never-executing words
      for (i = 0; i < 64; i++) imem[i] = 32'hF000_0000 | (word_t'(i) << 2);
      for (i = 0; i < 256; i++) dmem[i] = ~(word_t'(i) << 2) ^ 32'h5A00_0000;
      for (i = 0; i < 512; i++) pat[i] = '0;
      $readmemh("armCore_patterns.txt", pat);
      i = 0;
      while (i < 510 && pat[i] != '0) begin
         case (pat[i])
            32'd1: begin
               imem[pat[i+1][7:2]] = pat[i+2];
               progLen++;
            end
            32'd2: begin
               dmem[pat[i+1][9:2]] = pat[i+2];
               u_check.expectLoad(pat[i+1]);   // Each preload is read once
            end
            32'd3: u_check.expectStore(pat[i+1], pat[i+2]);
            default: begin
               loadError = 1'b1;
               $display("Pattern file has an unknown record tag %h", pat[i]);
            end
         endcase
         i += 3;
      end
      cycleLimit = 4 * progLen + 20;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      cycles = 0;
      while (u_check.remaining() != 0 && cycles < cycleLimit) begin
         @(posedge clk);
         cycles++;
      end
      timedOut = (u_check.remaining() != 0);
      if (timedOut) begin
         $display("Timeout after %0d cycles with %0d accesses missing",
                  cycles, u_check.remaining());
      end else begin
         repeat (8) @(posedge clk);   // Room for stray stores
      end
      $display("Accesses: %0d passed, %0d failed, %0d missing, %0d unexpected, %0d asserts",
               u_check.passCount, u_check.failCount, u_check.remaining(),
               u_check.extraCount, dut.u_props.failCount);
      if (!timedOut && !loadError && u_check.failCount == 0 && u_check.extraCount == 0
          && dut.u_props.failCount == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- armCore_patterns.txt
// Records of three hex words: tag, byte address, data
// Tag 1 program word, tag 2 data preload, tag 3 expected store in program order, tag 0 end
1 000 E3A00000  1 004 E3A01005  1 008 E3A02003  1 00C E281300A
1 010 E5803100  1 014 E2414002  1 018 E5804104  1 01C E0815002
1 020 E5805108  1 024 E0416002  1 028 E580610C  1 02C E2017006
1 030 E5807110  1 034 E0018002  1 038 E5808114  1 03C E3819010
1 040 E5809118  1 044 E181A002  1 048 E580A11C  1 04C E221B0FF
1 050 E580B120  1 054 E021C002  1 058 E580C124  1 05C E1A03002
// Flag setting and conditional stores
1 060 E5803128  1 064 E2514005  1 068 0580112C  1 06C 15801130
1 070 25802134  1 074 35802138  1 078 E2524005  1 07C 4580413C
1 080 B5802140  1 084 A5802144  1 088 E2915001  1 08C C5805148
1 090 1580514C  1 094 35805150  1 098 E0416001  1 09C 05806154
// Loads, R15 reads, branches and the final loop
1 0A0 15806158  1 0A4 E5907080  1 0A8 E580715C  1 0AC E5908084
1 0B0 E5808160  1 0B4 E28F9000  1 0B8 E5809164  1 0BC E580F168
1 0C0 EA000000  1 0C4 E580116C  1 0C8 E3A0A004  1 0CC E3A0B000
1 0D0 E28BB001  1 0D4 E25AA001  1 0D8 1AFFFFFC  1 0DC E580B16C
1 0E0 E580A170  1 0E4 EAFFFFFE
2 080 DEADBEEF  2 084 12345678
3 100 0000000F  3 104 00000003  3 108 00000008  3 10C 00000002
3 110 00000004  3 114 00000001  3 118 00000015  3 11C 00000007
3 120 000000FA  3 124 00000006  3 128 00000003  3 12C 00000005
3 134 00000003  3 13C FFFFFFFE  3 140 00000003  3 148 00000006
3 14C 00000006  3 150 00000006  3 158 00000000  3 15C DEADBEEF
3 160 12345678  3 164 000000BC  3 168 000000C4  3 16C 00000004
3 170 00000000
0 000 00000000

//--- armCore.f
+incdir+.
armPkg.sv
instrDecoder.sv
condUnit.sv
regFile.sv
alu.sv
datapath.sv
armCore.sv
armCore_properties.sv
armCore_checker.sv
armCore_tb.sv

//--- run.sh
#!/bin/bash
verilator --binary --timing --assert --top-module armCore_tb -f armCore.f -o simv \
   && ./obj_dir/simv | tee /dev/stderr | grep -q "^Test OK$" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
